// File: sources.f
src/aes_pkg.sv
src/aes_regfile.sv
src/aes_fsm.sv
src/aes_streamer.sv
src/aes_ark_engine.sv
src/aes_top.sv
verif/aes_mem_model.sv
verif/aes_tb.sv

// File: src/aes_ark_engine.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AddRoundKey engine with a four-word block buffer.
// Words are loaded by index, one step XORs the key in,
// results are read back by index.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module aes_ark_engine
  import aes_pkg::*;
(
  input  logic         clk,
  input  logic         reset_n,
  input  engine_ctrl_t ctrl_i,
  input  key_t         key_i,
  input  logic [1:0]   out_idx_i,
  output word_t        out_word_o
);

  word_t [3:0] blk_q;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      blk_q <= '0;
    end else if (ctrl_i.clear) begin
      blk_q <= '0;
    end else if (ctrl_i.load_en) begin
      blk_q[ctrl_i.word_idx] <= ctrl_i.load_data;
    end else if (ctrl_i.step) begin
      // Word n takes key word n
      for (int i = 0; i < 4; i++) begin
        blk_q[i] <= blk_q[i] ^ key_i[i];
      end
    end
  end

  assign out_word_o = blk_q[out_idx_i];

endmodule

// File: src/aes_fsm.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Controller FSM of the accelerator.
// Walks the job block by block: four word loads,
// one engine step, four word stores, next block.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module aes_fsm
  import aes_pkg::*;
#(
  parameter int ADDR_WIDTH = 16
) (
  input  logic            clk,
  input  logic            reset_n,
  input  logic            clear_i,
  input  logic            start_i,
  input  job_cfg_t        cfg_i,
  output streamer_ctrl_t  streamer_ctrl_o,
  input  streamer_flags_t streamer_flags_i,
  output engine_ctrl_t    engine_ctrl_o,
  input  word_t           engine_word_i,
  output logic            busy_o,
  output logic            done_o
);

  aes_state_t            state_q, state_d;
  logic [1:0]            word_cnt_q;
  byte_len_t             rem_q;
  byte_len_t             rem_next;
  logic [ADDR_WIDTH-1:0] in_blk_q, out_blk_q;
  logic [ADDR_WIDTH-1:0] word_off;
  logic [ADDR_WIDTH-1:0] word_addr;

  assign rem_next = rem_q - 32'd16;
  assign word_off = ADDR_WIDTH'({word_cnt_q, 2'b00});

  // Load phases read from the input block, store phases write the output block
  assign word_addr = (state_q == AES_SEND_DATA) ? out_blk_q + word_off
                                                 : in_blk_q + word_off;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q <= AES_IDLE;
    end else if (clear_i) begin
      state_q <= AES_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Word counter, remaining length and block addresses
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      word_cnt_q <= '0;
      rem_q      <= '0;
      in_blk_q   <= '0;
      out_blk_q  <= '0;
    end else if (clear_i) begin
      word_cnt_q <= '0;
    end else begin
      case (state_q)
        AES_STARTING: begin
          word_cnt_q <= '0;
          rem_q      <= {cfg_i.length[31:4], 4'b0000};
          in_blk_q   <= cfg_i.in_addr[ADDR_WIDTH-1:0];
          out_blk_q  <= cfg_i.out_addr[ADDR_WIDTH-1:0];
        end
        AES_REQUEST_DATA_WAIT: begin
          if (streamer_flags_i.load_done) word_cnt_q <= word_cnt_q + 2'd1;
        end
        AES_SEND_DATA_WAIT: begin
          if (streamer_flags_i.store_done) word_cnt_q <= word_cnt_q + 2'd1;
        end
        AES_BLOCK_NEXT: begin
          rem_q     <= rem_next;
          in_blk_q  <= in_blk_q + ADDR_WIDTH'(16);
          out_blk_q <= out_blk_q + ADDR_WIDTH'(16);
        end
        default: ;
      endcase
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      AES_IDLE: begin
        if (start_i) state_d = AES_STARTING;
      end
      AES_STARTING: begin
        // Lengths under one block finish without touching memory
        if (cfg_i.length[31:4] == '0) state_d = AES_FINISHED;
        else                          state_d = AES_REQUEST_DATA;
      end
      AES_REQUEST_DATA: begin
        if (streamer_flags_i.load_ready) state_d = AES_REQUEST_DATA_WAIT;
      end
      AES_REQUEST_DATA_WAIT: begin
        if (streamer_flags_i.load_done) begin
          state_d = (word_cnt_q == 2'd3) ? AES_WORKING : AES_REQUEST_DATA;
        end
      end
      AES_WORKING:   state_d = AES_SEND_DATA;
      AES_SEND_DATA: begin
        if (streamer_flags_i.store_ready) state_d = AES_SEND_DATA_WAIT;
      end
      AES_SEND_DATA_WAIT: begin
        if (streamer_flags_i.store_done) begin
          state_d = (word_cnt_q == 2'd3) ? AES_BLOCK_NEXT : AES_SEND_DATA;
        end
      end
      AES_BLOCK_NEXT: begin
        state_d = (rem_next == '0) ? AES_FINISHED : AES_REQUEST_DATA;
      end
      AES_FINISHED:  state_d = AES_IDLE;
      default:       state_d = AES_IDLE;
    endcase
  end

  // Strobes to streamer and engine
  always_comb begin
    streamer_ctrl_o             = '0;
    streamer_ctrl_o.addr        = 32'(word_addr);
    streamer_ctrl_o.store_data  = engine_word_i;
    streamer_ctrl_o.load_start  = (state_q == AES_REQUEST_DATA) &&
                                  streamer_flags_i.load_ready;
    streamer_ctrl_o.store_start = (state_q == AES_SEND_DATA) &&
                                  streamer_flags_i.store_ready;

    engine_ctrl_o           = '0;
    engine_ctrl_o.clear     = clear_i || (state_q == AES_IDLE);
    engine_ctrl_o.word_idx  = word_cnt_q;
    engine_ctrl_o.load_data = streamer_flags_i.load_data;
    engine_ctrl_o.load_en   = (state_q == AES_REQUEST_DATA_WAIT) &&
                              streamer_flags_i.load_done;
    engine_ctrl_o.step      = (state_q == AES_WORKING);
  end

  assign busy_o = start_i || (state_q != AES_IDLE);
  assign done_o = (state_q == AES_FINISHED);

endmodule

// File: src/aes_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types for the cipher accelerator.
// Imported by every RTL module and by the testbench
// for the register map and the job structs.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package aes_pkg;

  typedef logic [31:0]      word_t;
  typedef word_t [3:0]      key_t;
  typedef logic [31:0]      byte_len_t;
  typedef logic [5:0]       reg_addr_t;

  // Register map, byte offsets
  localparam reg_addr_t REG_START    = 6'h00;
  localparam reg_addr_t REG_STATUS   = 6'h04;
  localparam reg_addr_t REG_IN_ADDR  = 6'h08;
  localparam reg_addr_t REG_OUT_ADDR = 6'h0C;
  localparam reg_addr_t REG_LENGTH   = 6'h10;
  localparam reg_addr_t REG_KEY0     = 6'h14;
  localparam reg_addr_t REG_KEY1     = 6'h18;
  localparam reg_addr_t REG_KEY2     = 6'h1C;
  localparam reg_addr_t REG_KEY3     = 6'h20;

  typedef enum logic [3:0] {
    AES_IDLE,
    AES_STARTING,
    AES_REQUEST_DATA,
    AES_REQUEST_DATA_WAIT,
    AES_WORKING,
    AES_SEND_DATA,
    AES_SEND_DATA_WAIT,
    AES_BLOCK_NEXT,
    AES_FINISHED
  } aes_state_t;

  typedef struct packed {
    word_t     in_addr;
    word_t     out_addr;
    byte_len_t length;
    key_t      key;
  } job_cfg_t;

  typedef struct packed {
    logic  load_start;
    logic  store_start;
    word_t addr;
    word_t store_data;
  } streamer_ctrl_t;

  typedef struct packed {
    logic  load_ready;
    logic  load_done;
    word_t load_data;
    logic  store_ready;
    logic  store_done;
  } streamer_flags_t;

  typedef struct packed {
    logic       clear;
    logic       load_en;
    logic [1:0] word_idx;
    word_t      load_data;
    logic       step;
  } engine_ctrl_t;

endpackage

// File: src/aes_regfile.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register slave of the accelerator.
// Holds job addresses, length and key, turns a
// write to the start register into a start pulse.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module aes_regfile
  import aes_pkg::*;
(
  input  logic      clk,
  input  logic      reset_n,
  input  logic      reg_wr_i,
  input  logic      reg_rd_i,
  input  reg_addr_t reg_addr_i,
  input  word_t     reg_wdata_i,
  output word_t     reg_rdata_o,
  input  logic      busy_i,
  output logic      start_o,
  output job_cfg_t  cfg_o
);

  job_cfg_t cfg_q;
  logic     start_q;
  logic     wr_allowed;

  // Parameters stay frozen while a job runs
  assign wr_allowed = reg_wr_i && !busy_i;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      cfg_q   <= '0;
      start_q <= 1'b0;
    end else begin
      start_q <= wr_allowed && (reg_addr_i == REG_START);
      if (wr_allowed) begin
        case (reg_addr_i)
          REG_IN_ADDR:  cfg_q.in_addr  <= reg_wdata_i;
          REG_OUT_ADDR: cfg_q.out_addr <= reg_wdata_i;
          REG_LENGTH:   cfg_q.length   <= reg_wdata_i;
          REG_KEY0:     cfg_q.key[0]   <= reg_wdata_i;
          REG_KEY1:     cfg_q.key[1]   <= reg_wdata_i;
          REG_KEY2:     cfg_q.key[2]   <= reg_wdata_i;
          REG_KEY3:     cfg_q.key[3]   <= reg_wdata_i;
          default: ;
        endcase
      end
    end
  end

  // Read mux, start register reads as zero
  always_comb begin
    reg_rdata_o = '0;
    if (reg_rd_i) begin
      case (reg_addr_i)
        REG_STATUS:   reg_rdata_o = {31'b0, busy_i};
        REG_IN_ADDR:  reg_rdata_o = cfg_q.in_addr;
        REG_OUT_ADDR: reg_rdata_o = cfg_q.out_addr;
        REG_LENGTH:   reg_rdata_o = cfg_q.length;
        REG_KEY0:     reg_rdata_o = cfg_q.key[0];
        REG_KEY1:     reg_rdata_o = cfg_q.key[1];
        REG_KEY2:     reg_rdata_o = cfg_q.key[2];
        REG_KEY3:     reg_rdata_o = cfg_q.key[3];
        default:      reg_rdata_o = '0;
      endcase
    end
  end

  assign start_o = start_q;
  assign cfg_o   = cfg_q;

endmodule

// File: src/aes_streamer.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Single-word load and store unit.
// Turns controller start pulses into memory requests
// and reports ready and done flags back.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module aes_streamer
  import aes_pkg::*;
#(
  parameter int ADDR_WIDTH = 16
) (
  input  logic                  clk,
  input  logic                  reset_n,
  input  streamer_ctrl_t        ctrl_i,
  output streamer_flags_t       flags_o,
  output logic                  mem_req_o,
  output logic                  mem_we_o,
  output logic [ADDR_WIDTH-1:0] mem_addr_o,
  output word_t                 mem_wdata_o,
  input  word_t                 mem_rdata_i,
  input  logic                  mem_rvalid_i
);

  logic load_pend_q;
  logic store_done_q;
  logic load_done;

  // Read data belongs to us only while a load is outstanding
  assign load_done = load_pend_q && mem_rvalid_i;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      load_pend_q <= 1'b0;
    end else if (ctrl_i.load_start) begin
      load_pend_q <= 1'b1;
    end else if (load_done) begin
      load_pend_q <= 1'b0;
    end
  end

  // Writes complete at the request edge, done follows one cycle later
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      store_done_q <= 1'b0;
    end else begin
      store_done_q <= ctrl_i.store_start;
    end
  end

  assign mem_req_o   = ctrl_i.load_start || ctrl_i.store_start;
  assign mem_we_o    = ctrl_i.store_start;
  assign mem_addr_o  = ctrl_i.addr[ADDR_WIDTH-1:0];
  assign mem_wdata_o = ctrl_i.store_data;

  always_comb begin
    flags_o             = '0;
    flags_o.load_ready  = !load_pend_q;
    flags_o.load_done   = load_done;
    flags_o.load_data   = mem_rdata_i;
    flags_o.store_ready = !load_pend_q;
    flags_o.store_done  = store_done_q;
  end

endmodule

// File: src/aes_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Top level of the cipher accelerator.
// Register bus in, word memory port out,
// done pulse at the end of each job.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module aes_top
  import aes_pkg::*;
#(
  parameter int ADDR_WIDTH = 16
) (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  clear_i,
  // Register bus
  input  logic                  reg_wr_i,
  input  logic                  reg_rd_i,
  input  reg_addr_t             reg_addr_i,
  input  word_t                 reg_wdata_i,
  output word_t                 reg_rdata_o,
  // Memory port
  output logic                  mem_req_o,
  output logic                  mem_we_o,
  output logic [ADDR_WIDTH-1:0] mem_addr_o,
  output word_t                 mem_wdata_o,
  input  word_t                 mem_rdata_i,
  input  logic                  mem_rvalid_i,
  output logic                  done_o
);

  job_cfg_t        cfg;
  logic            start;
  logic            busy;
  streamer_ctrl_t  streamer_ctrl;
  streamer_flags_t streamer_flags;
  engine_ctrl_t    engine_ctrl;
  word_t           engine_word;

  aes_regfile aes_regfile_inst (
    .clk         (clk),
    .reset_n     (reset_n),
    .reg_wr_i    (reg_wr_i),
    .reg_rd_i    (reg_rd_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_rdata_o (reg_rdata_o),
    .busy_i      (busy),
    .start_o     (start),
    .cfg_o       (cfg)
  );

  aes_fsm #(.ADDR_WIDTH(ADDR_WIDTH)) aes_fsm_inst (
    .clk              (clk),
    .reset_n          (reset_n),
    .clear_i          (clear_i),
    .start_i          (start),
    .cfg_i            (cfg),
    .streamer_ctrl_o  (streamer_ctrl),
    .streamer_flags_i (streamer_flags),
    .engine_ctrl_o    (engine_ctrl),
    .engine_word_i    (engine_word),
    .busy_o           (busy),
    .done_o           (done_o)
  );

  aes_streamer #(.ADDR_WIDTH(ADDR_WIDTH)) aes_streamer_inst (
    .clk          (clk),
    .reset_n      (reset_n),
    .ctrl_i       (streamer_ctrl),
    .flags_o      (streamer_flags),
    .mem_req_o    (mem_req_o),
    .mem_we_o     (mem_we_o),
    .mem_addr_o   (mem_addr_o),
    .mem_wdata_o  (mem_wdata_o),
    .mem_rdata_i  (mem_rdata_i),
    .mem_rvalid_i (mem_rvalid_i)
  );

  // Result word follows the controller's word counter
  aes_ark_engine aes_ark_engine_inst (
    .clk        (clk),
    .reset_n    (reset_n),
    .ctrl_i     (engine_ctrl),
    .key_i      (cfg.key),
    .out_idx_i  (engine_ctrl.word_idx),
    .out_word_o (engine_word)
  );

endmodule

// File: verif/aes_mem_model.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Word memory for the testbench.
// Serves the DUT memory port, read data and rvalid
// one cycle after the request, writes at the request edge.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module aes_mem_model
  import aes_pkg::*;
#(
  parameter int ADDR_WIDTH = 16
) (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  req_i,
  input  logic                  we_i,
  input  logic [ADDR_WIDTH-1:0] addr_i,
  input  word_t                 wdata_i,
  output word_t                 rdata_o,
  output logic                  rvalid_o
);

  localparam int DEPTH = 2 ** (ADDR_WIDTH - 2);

  word_t mem [0:DEPTH-1];

  initial begin
    // Background pattern from the full word index
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = (32'(i) * 32'h9E37_79B1) ^ 32'h5A5A_0F0F;
    end
  end

  always @(posedge clk) begin
    if (req_i && we_i) begin
      mem[addr_i[ADDR_WIDTH-1:2]] <= wdata_i;
    end
  end

  always @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      rdata_o  <= '0;
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= req_i && !we_i;
      if (req_i && !we_i) begin
        rdata_o <= mem[addr_i[ADDR_WIDTH-1:2]];
      end
    end
  end

endmodule

// File: verif/aes_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the cipher accelerator.
// Runs random jobs through the register bus and checks
// memory results against an AddRoundKey model.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module aes_tb
  import aes_pkg::*;
();

  localparam int ADDR_WIDTH   = 16;
  localparam int NUM_JOBS     = 10;
  localparam int MAX_BLOCKS   = 8;
  // Zero, short, odd length, aborted and follow-up jobs plus setup
  localparam int EXTRA_JOBS   = 6;
  localparam int EXTRA_BLOCKS = 16;
  localparam int TIMEOUT_CYCLES = (NUM_JOBS * MAX_BLOCKS + EXTRA_BLOCKS) * 64 +
                                  (NUM_JOBS + EXTRA_JOBS) * 200;

  logic                  clk;
  logic                  reset_n;
  logic                  clear_i;
  logic                  reg_wr;
  logic                  reg_rd;
  reg_addr_t             reg_addr;
  word_t                 reg_wdata;
  word_t                 reg_rdata;
  logic                  mem_req;
  logic                  mem_we;
  logic [ADDR_WIDTH-1:0] mem_addr;
  word_t                 mem_wdata;
  word_t                 mem_rdata;
  logic                  mem_rvalid;
  logic                  done;

  int cycle_count    = 0;
  int done_count     = 0;
  int req_count      = 0;
  int expected_dones = 0;

  aes_top #(.ADDR_WIDTH(ADDR_WIDTH)) aes_top_inst (
    .clk          (clk),
    .reset_n      (reset_n),
    .clear_i      (clear_i),
    .reg_wr_i     (reg_wr),
    .reg_rd_i     (reg_rd),
    .reg_addr_i   (reg_addr),
    .reg_wdata_i  (reg_wdata),
    .reg_rdata_o  (reg_rdata),
    .mem_req_o    (mem_req),
    .mem_we_o     (mem_we),
    .mem_addr_o   (mem_addr),
    .mem_wdata_o  (mem_wdata),
    .mem_rdata_i  (mem_rdata),
    .mem_rvalid_i (mem_rvalid),
    .done_o       (done)
  );

  aes_mem_model #(.ADDR_WIDTH(ADDR_WIDTH)) mem_model_inst (
    .clk      (clk),
    .reset_n  (reset_n),
    .req_i    (mem_req),
    .we_i     (mem_we),
    .addr_i   (mem_addr),
    .wdata_i  (mem_wdata),
    .rdata_o  (mem_rdata),
    .rvalid_o (mem_rvalid)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  // Pulse counters, sampled mid-cycle
  always @(negedge clk) begin
    if (done) done_count++;
    if (mem_req) req_count++;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      stop_on_failure($sformatf("Timeout after %0d cycles, a job never finished",
                                cycle_count));
    end
  end

  task automatic stop_on_failure(input string reason);
    $display("%s", reason);
    $display("Test failed");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_equal(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      stop_on_failure($sformatf("FAIL %s expected 0x%08h actual 0x%08h",
                                name, expected, actual));
    end
  endtask

  task automatic write_reg(input reg_addr_t addr, input word_t data);
    @(negedge clk);
    reg_wr    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(negedge clk);
    reg_wr = 1'b0;
  endtask

  task automatic read_reg(input reg_addr_t addr, output word_t data);
    @(negedge clk);
    reg_rd   = 1'b1;
    reg_addr = addr;
    #2;
    data = reg_rdata;
    @(negedge clk);
    reg_rd = 1'b0;
  endtask

  task automatic program_regs(input word_t in_addr, input word_t out_addr,
                              input byte_len_t length, input key_t key);
    write_reg(REG_IN_ADDR, in_addr);
    write_reg(REG_OUT_ADDR, out_addr);
    write_reg(REG_LENGTH, length);
    for (int k = 0; k < 4; k++) begin
      write_reg(REG_KEY0 + reg_addr_t'(4 * k), key[k]);
    end
  endtask

  // Status must read busy every cycle until the done pulse
  task automatic wait_for_done();
    forever begin
      @(negedge clk);
      if (done) break;
      reg_rd   = 1'b1;
      reg_addr = REG_STATUS;
      #2;
      check_equal("REG_STATUS busy", 32'd1, reg_rdata);
    end
    reg_rd = 1'b0;
  endtask

  task automatic run_job(input word_t in_addr, input word_t out_addr, input byte_len_t length,
                         input key_t key, input bit poke_busy);
    int    blocks;
    int    in_w;
    int    out_w;
    int    req_before;
    word_t w;
    word_t status;
    word_t guard_lo;
    word_t guard_hi;
    word_t src [$];
    blocks = int'(length >> 4);
    in_w   = int'(in_addr >> 2);
    out_w  = int'(out_addr >> 2);
    for (int n = 0; n < blocks * 4; n++) begin
      w = $urandom;
      mem_model_inst.mem[in_w + n] = w;
      src.push_back(w);
    end
    // Output range plus one guard word on each side
    for (int n = -1; n <= blocks * 4; n++) begin
      mem_model_inst.mem[out_w + n] = $urandom;
    end
    guard_lo = mem_model_inst.mem[out_w - 1];
    guard_hi = mem_model_inst.mem[out_w + blocks * 4];

    program_regs(in_addr, out_addr, length, key);
    check_equal("done pulses before job", expected_dones, done_count);
    req_before = req_count;
    write_reg(REG_START, $urandom);
    expected_dones++;
    if (poke_busy) begin
      write_reg(REG_IN_ADDR, in_addr ^ 32'h0000_0400);
      write_reg(REG_KEY0, ~key[0]);
      write_reg(REG_LENGTH, 32'd0);
    end
    wait_for_done();
    read_reg(REG_STATUS, status);
    check_equal("REG_STATUS after done", 32'd0, status);
    check_equal("done pulses after job", expected_dones, done_count);
    check_equal("memory requests", blocks * 8, req_count - req_before);
    if (poke_busy) begin
      read_reg(REG_IN_ADDR, status);
      check_equal("REG_IN_ADDR after busy write", in_addr, status);
    end

    for (int n = 0; n < blocks * 4; n++) begin
      check_equal($sformatf("mem[0x%04h]", out_addr + 4 * n),
                  src[n] ^ key[n % 4], mem_model_inst.mem[out_w + n]);
    end
    check_equal("guard word below output", guard_lo, mem_model_inst.mem[out_w - 1]);
    check_equal("guard word above output", guard_hi, mem_model_inst.mem[out_w + blocks * 4]);
  endtask

  initial begin
    word_t     in_addr;
    word_t     out_addr;
    word_t     value;
    byte_len_t length;
    key_t      key;
    void'($urandom(82));
    reset_n   = 1'b0;
    clear_i   = 1'b0;
    reg_wr    = 1'b0;
    reg_rd    = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    repeat (3) @(negedge clk);
    reset_n = 1'b1;

    // Idle after reset
    read_reg(REG_STATUS, value);
    check_equal("REG_STATUS after reset", 32'd0, value);
    repeat (10) begin
      @(negedge clk);
      check_equal("done_o idle", 32'd0, 32'(done));
      check_equal("mem_req_o idle", 32'd0, 32'(mem_req));
    end

    // Register readback
    for (int k = 0; k < 4; k++) key[k] = $urandom;
    in_addr  = $urandom;
    out_addr = $urandom;
    length   = $urandom;
    program_regs(in_addr, out_addr, length, key);
    read_reg(REG_IN_ADDR, value);
    check_equal("REG_IN_ADDR", in_addr, value);
    read_reg(REG_OUT_ADDR, value);
    check_equal("REG_OUT_ADDR", out_addr, value);
    read_reg(REG_LENGTH, value);
    check_equal("REG_LENGTH", length, value);
    for (int k = 0; k < 4; k++) begin
      read_reg(REG_KEY0 + reg_addr_t'(4 * k), value);
      check_equal($sformatf("REG_KEY%0d", k), key[k], value);
    end
    @(negedge clk);
    reg_addr = REG_LENGTH;
    #2;
    check_equal("reg_rdata_o without read", 32'd0, reg_rdata);

    // Random jobs, input and output regions far apart
    for (int j = 0; j < NUM_JOBS; j++) begin
      in_addr  = word_t'((($urandom % 2048) + 16) * 4);
      out_addr = word_t'((($urandom % 2048) + 8192) * 4);
      length   = byte_len_t'((1 + ($urandom % MAX_BLOCKS)) * 16);
      for (int k = 0; k < 4; k++) key[k] = $urandom;
      run_job(in_addr, out_addr, length, key, j == 3);
    end

    // Lengths without a whole block, then a length with low bits set
    run_job(32'h0000_0100, 32'h0000_9000, 32'd0, key, 1'b0);
    run_job(32'h0000_0100, 32'h0000_9000, 32'd12, key, 1'b0);
    run_job(32'h0000_0200, 32'h0000_A000, 32'd57, key, 1'b0);

    // Abort a running job, nothing may complete
    program_regs(32'h0000_0300, 32'h0000_B000, 32'd64, key);
    write_reg(REG_START, 32'd1);
    repeat (20) @(negedge clk);
    clear_i = 1'b1;
    @(negedge clk);
    clear_i = 1'b0;
    repeat (10) @(negedge clk);
    read_reg(REG_STATUS, value);
    check_equal("REG_STATUS after clear", 32'd0, value);
    check_equal("done pulses after clear", expected_dones, done_count);

    for (int k = 0; k < 4; k++) key[k] = $urandom;
    length = byte_len_t'((1 + ($urandom % MAX_BLOCKS)) * 16);
    run_job(32'h0000_0400, 32'h0000_C000, length, key, 1'b0);

    $display("Test completed successfully");
    $finish;
  end

endmodule
